// File: rtl/issue_cfg.svh
// issue stage sizing
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// status rows: alu, load/store, branch
`define ISSUE_ROWS 3

// datapath word
`define ISSUE_DATA_W 32

// register index, 32 architectural registers
`define ISSUE_REG_W 5

// row age counter, saturates at all ones
`define ISSUE_AGE_W 3

// op code handed to the unit
`define ISSUE_OP_W 4

`endif

// File: rtl/issue_pkg.sv
// issue stage types
`include "issue_cfg.svh"

package issue_pkg;

    // data word, also carries the immediate
    typedef logic [`ISSUE_DATA_W-1:0] word_t;

    // architectural register index
    typedef logic [`ISSUE_REG_W-1:0] regbits_t;

    // row age, larger is older
    typedef logic [`ISSUE_AGE_W-1:0] age_t;

    // op code passed through to the unit
    typedef logic [`ISSUE_OP_W-1:0] op_type_t;

    // one bit per row
    // used for pending masks, busy flags, done pulses and issue enables
    typedef logic [`ISSUE_ROWS-1:0] row_mask_t;

    // row index, doubles as the unit select from dispatch
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_LDST   = 2'd1,
        FU_BRANCH = 2'd2
    } fu_row_e;

    // per row life cycle
    // empty -> wait on dispatch, wait -> rdy when nothing pending,
    // rdy -> ex when selected, ex -> empty on done
    typedef enum logic [1:0] {
        FUST_EMPTY = 2'd0,
        FUST_WAIT  = 2'd1,
        FUST_RDY   = 2'd2,
        FUST_EX    = 2'd3
    } fust_state_e;

endpackage

// File: rtl/issue_regfile.sv
// issue register file
`timescale 1ns/100ps
`include "issue_cfg.svh"

module issue_regfile (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               wen,
    input  issue_pkg::regbits_t wsel,
    input  issue_pkg::word_t   wdata,
    input  issue_pkg::regbits_t rsel1,
    input  issue_pkg::regbits_t rsel2,
    output issue_pkg::word_t   rdat1,
    output issue_pkg::word_t   rdat2
);
    import issue_pkg::*;

    localparam int NREGS = 1 << `ISSUE_REG_W;

    word_t regs [NREGS];

    // one read port: r0 reads zero, a same cycle write is forwarded
    function automatic word_t read_port(input regbits_t sel);
        word_t val;
        if (sel == '0) begin
            val = '0;
        end else if (wen && (wsel == sel)) begin
            val = wdata;
        end else begin
            val = regs[sel];
        end
        return val;
    endfunction

    // writes to r0 are dropped so it stays zero after reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wsel != '0)) begin
            regs[wsel] <= wdata;
        end
    end

    always_comb begin
        rdat1 = read_port(rsel1);
        rdat2 = read_port(rsel2);
    end

endmodule

// File: rtl/dispatch_intake.sv
// dispatch intake for the status rows
`timescale 1ns/100ps
`include "issue_cfg.svh"

module dispatch_intake (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 disp_en,
    input  issue_pkg::fu_row_e   disp_fu,
    input  issue_pkg::regbits_t  disp_rs1,
    input  issue_pkg::regbits_t  disp_rs2,
    input  issue_pkg::regbits_t  disp_rd,
    input  issue_pkg::word_t     disp_imm,
    input  issue_pkg::op_type_t  disp_op,
    input  logic                 disp_i_type,
    input  logic                 disp_lui,
    input  issue_pkg::row_mask_t disp_wait,
    input  issue_pkg::row_mask_t fu_done,
    output issue_pkg::row_mask_t dispatched,
    output issue_pkg::row_mask_t row_pending [`ISSUE_ROWS],
    output issue_pkg::regbits_t  row_rs1 [`ISSUE_ROWS],
    output issue_pkg::regbits_t  row_rs2 [`ISSUE_ROWS],
    output issue_pkg::regbits_t  row_rd [`ISSUE_ROWS],
    output issue_pkg::word_t     row_imm [`ISSUE_ROWS],
    output issue_pkg::op_type_t  row_op [`ISSUE_ROWS],
    output logic                 row_i_type [`ISSUE_ROWS],
    output logic                 row_lui [`ISSUE_ROWS]
);
    import issue_pkg::*;

    row_mask_t wr_row;

    // unit select to row mask
    // an out of range select shifts out and writes nothing
    always_comb begin
        wr_row = row_mask_t'(1) << disp_fu;
        dispatched = disp_en ? wr_row : '0;
    end

    // instruction fields, only the written row changes
    always_ff @(posedge CLK) begin
        for (int i = 0; i < `ISSUE_ROWS; i++) begin
            if (dispatched[i]) begin
                row_rs1[i]    <= disp_rs1;
                row_rs2[i]    <= disp_rs2;
                row_rd[i]     <= disp_rd;
                row_imm[i]    <= disp_imm;
                row_op[i]     <= disp_op;
                row_i_type[i] <= disp_i_type;
                row_lui[i]    <= disp_lui;
            end
        end
    end

    // pending units per row
    // a done pulse knocks its bit out of every mask, including one loaded now
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `ISSUE_ROWS; i++) begin
                row_pending[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `ISSUE_ROWS; i++) begin
                if (dispatched[i]) begin
                    row_pending[i] <= disp_wait & ~fu_done;
                end else begin
                    row_pending[i] <= row_pending[i] & ~fu_done;
                end
            end
        end
    end

endmodule

// File: rtl/fu_status_table.sv
// functional unit status table and oldest first select
`timescale 1ns/100ps
`include "issue_cfg.svh"

module fu_status_table (
    input  logic                 CLK,
    input  logic                 nRST,
    input  issue_pkg::row_mask_t dispatched,
    input  issue_pkg::row_mask_t row_pending [`ISSUE_ROWS],
    input  issue_pkg::row_mask_t fu_done,
    input  logic                 branch_miss,
    output logic                 sel_valid,
    output issue_pkg::fu_row_e   sel_row,
    output issue_pkg::row_mask_t fu_busy
);
    import issue_pkg::*;

    localparam age_t AGE_MAX = {`ISSUE_AGE_W{1'b1}};

    fust_state_e state [`ISSUE_ROWS];
    fust_state_e next_state [`ISSUE_ROWS];
    age_t        age [`ISSUE_ROWS];
    age_t        next_age [`ISSUE_ROWS];
    row_mask_t   rdy;
    logic        rdy_any;
    age_t        best_age;
    fu_row_e     best_row;

    // busy until the row is back to empty, i.e. the edge after fu_done
    always_comb begin
        for (int i = 0; i < `ISSUE_ROWS; i++) begin
            rdy[i]     = (state[i] == FUST_RDY);
            fu_busy[i] = (state[i] != FUST_EMPTY);
        end
    end

    // oldest ready row wins
    // strict compare keeps the lower row on a tie
    always_comb begin
        rdy_any  = 1'b0;
        best_age = '0;
        best_row = FU_ALU;
        for (int i = 0; i < `ISSUE_ROWS; i++) begin
            if (rdy[i] && (!rdy_any || (age[i] > best_age))) begin
                rdy_any  = 1'b1;
                best_age = age[i];
                best_row = fu_row_e'(i);
            end
        end
    end

    // flush cycle issues nothing
    assign sel_valid = rdy_any && !branch_miss;
    assign sel_row   = best_row;

    // row state machines
    always_comb begin
        for (int i = 0; i < `ISSUE_ROWS; i++) begin
            next_state[i] = state[i];
            if (branch_miss) begin
                next_state[i] = FUST_EMPTY;
            end else begin
                case (state[i])
                    FUST_EMPTY: begin
                        if (dispatched[i]) begin
                            next_state[i] = FUST_WAIT;
                        end
                    end
                    FUST_WAIT: begin
                        // all producers have reported done
                        if (row_pending[i] == '0) begin
                            next_state[i] = FUST_RDY;
                        end
                    end
                    FUST_RDY: begin
                        if (sel_valid && (sel_row == fu_row_e'(i))) begin
                            next_state[i] = FUST_EX;
                        end
                    end
                    FUST_EX: begin
                        if (fu_done[i]) begin
                            next_state[i] = FUST_EMPTY;
                        end
                    end
                    default: next_state[i] = FUST_EMPTY;
                endcase
            end
        end
    end

    // ages
    // new row starts at 1, every dispatch bumps the occupied rows
    always_comb begin
        for (int i = 0; i < `ISSUE_ROWS; i++) begin
            if (next_state[i] == FUST_EMPTY) begin
                next_age[i] = '0;
            end else if (dispatched[i]) begin
                next_age[i] = age_t'(1);
            end else if ((|dispatched) && (age[i] != AGE_MAX)) begin
                next_age[i] = age[i] + age_t'(1);
            end else begin
                next_age[i] = age[i];
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `ISSUE_ROWS; i++) begin
                state[i] <= FUST_EMPTY;
                age[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < `ISSUE_ROWS; i++) begin
                state[i] <= next_state[i];
                age[i]   <= next_age[i];
            end
        end
    end

endmodule

// File: rtl/operand_read.sv
// operand read and issue register
`timescale 1ns/100ps
`include "issue_cfg.svh"

module operand_read (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 sel_valid,
    input  issue_pkg::fu_row_e   sel_row,
    input  issue_pkg::regbits_t  row_rs1 [`ISSUE_ROWS],
    input  issue_pkg::regbits_t  row_rs2 [`ISSUE_ROWS],
    input  issue_pkg::regbits_t  row_rd [`ISSUE_ROWS],
    input  issue_pkg::word_t     row_imm [`ISSUE_ROWS],
    input  issue_pkg::op_type_t  row_op [`ISSUE_ROWS],
    input  logic                 row_i_type [`ISSUE_ROWS],
    input  logic                 row_lui [`ISSUE_ROWS],
    input  issue_pkg::word_t     rdat1,
    input  issue_pkg::word_t     rdat2,
    output issue_pkg::regbits_t  rsel1,
    output issue_pkg::regbits_t  rsel2,
    output logic                 iss_valid,
    output issue_pkg::row_mask_t iss_fu_en,
    output issue_pkg::op_type_t  iss_op,
    output issue_pkg::regbits_t  iss_rd,
    output issue_pkg::word_t     iss_rdat1,
    output issue_pkg::word_t     iss_rdat2,
    output issue_pkg::word_t     iss_imm
);
    import issue_pkg::*;

    word_t     op1;
    word_t     op2;
    logic      imm_op2;
    row_mask_t fu_onehot;

    // read selects follow the row being selected this cycle
    assign rsel1 = row_rs1[sel_row];
    assign rsel2 = row_rs2[sel_row];

    // operand forming
    // lui drops rs1, only i-type alu ops take the immediate as op2
    always_comb begin
        op1       = row_lui[sel_row] ? '0 : rdat1;
        imm_op2   = row_i_type[sel_row] && (sel_row == FU_ALU);
        op2       = imm_op2 ? row_imm[sel_row] : rdat2;
        fu_onehot = row_mask_t'(1) << sel_row;
    end

    // valid and unit enable pulse for one cycle per issue
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            iss_valid <= 1'b0;
            iss_fu_en <= '0;
        end else begin
            iss_valid <= sel_valid;
            iss_fu_en <= sel_valid ? fu_onehot : '0;
        end
    end

    // issue payload, held between issues
    always_ff @(posedge CLK) begin
        if (sel_valid) begin
            iss_op    <= row_op[sel_row];
            iss_rd    <= row_rd[sel_row];
            iss_rdat1 <= op1;
            iss_rdat2 <= op2;
            iss_imm   <= row_imm[sel_row];
        end
    end

endmodule

// File: rtl/issue_stage.sv
// issue stage top
`timescale 1ns/100ps
`include "issue_cfg.svh"

module issue_stage (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 disp_en,
    input  issue_pkg::fu_row_e   disp_fu,
    input  issue_pkg::regbits_t  disp_rs1,
    input  issue_pkg::regbits_t  disp_rs2,
    input  issue_pkg::regbits_t  disp_rd,
    input  issue_pkg::word_t     disp_imm,
    input  issue_pkg::op_type_t  disp_op,
    input  logic                 disp_i_type,
    input  logic                 disp_lui,
    input  issue_pkg::row_mask_t disp_wait,
    input  logic                 wb_en,
    input  issue_pkg::regbits_t  wb_sel,
    input  issue_pkg::word_t     wb_data,
    input  issue_pkg::row_mask_t fu_done,
    input  logic                 branch_miss,
    output issue_pkg::row_mask_t fu_busy,
    output logic                 iss_valid,
    output issue_pkg::row_mask_t iss_fu_en,
    output issue_pkg::op_type_t  iss_op,
    output issue_pkg::regbits_t  iss_rd,
    output issue_pkg::word_t     iss_rdat1,
    output issue_pkg::word_t     iss_rdat2,
    output issue_pkg::word_t     iss_imm
);
    import issue_pkg::*;

    // intake to table and operand read
    row_mask_t dispatched;
    row_mask_t row_pending [`ISSUE_ROWS];
    regbits_t  row_rs1 [`ISSUE_ROWS];
    regbits_t  row_rs2 [`ISSUE_ROWS];
    regbits_t  row_rd [`ISSUE_ROWS];
    word_t     row_imm [`ISSUE_ROWS];
    op_type_t  row_op [`ISSUE_ROWS];
    logic      row_i_type [`ISSUE_ROWS];
    logic      row_lui [`ISSUE_ROWS];

    // selection
    logic      sel_valid;
    fu_row_e   sel_row;

    // register file ports
    regbits_t  rsel1;
    regbits_t  rsel2;
    word_t     rdat1;
    word_t     rdat2;

    dispatch_intake u_intake (
        .CLK(CLK), .nRST(nRST), .disp_en(disp_en), .disp_fu(disp_fu),
        .disp_rs1(disp_rs1), .disp_rs2(disp_rs2), .disp_rd(disp_rd),
        .disp_imm(disp_imm), .disp_op(disp_op), .disp_i_type(disp_i_type),
        .disp_lui(disp_lui), .disp_wait(disp_wait), .fu_done(fu_done),
        .dispatched(dispatched), .row_pending(row_pending),
        .row_rs1(row_rs1), .row_rs2(row_rs2), .row_rd(row_rd), .row_imm(row_imm),
        .row_op(row_op), .row_i_type(row_i_type), .row_lui(row_lui)
    );

    fu_status_table u_table (
        .CLK(CLK), .nRST(nRST), .dispatched(dispatched), .row_pending(row_pending),
        .fu_done(fu_done), .branch_miss(branch_miss),
        .sel_valid(sel_valid), .sel_row(sel_row), .fu_busy(fu_busy)
    );

    operand_read u_opread (
        .CLK(CLK), .nRST(nRST), .sel_valid(sel_valid), .sel_row(sel_row),
        .row_rs1(row_rs1), .row_rs2(row_rs2), .row_rd(row_rd), .row_imm(row_imm),
        .row_op(row_op), .row_i_type(row_i_type), .row_lui(row_lui),
        .rdat1(rdat1), .rdat2(rdat2), .rsel1(rsel1), .rsel2(rsel2),
        .iss_valid(iss_valid), .iss_fu_en(iss_fu_en), .iss_op(iss_op),
        .iss_rd(iss_rd), .iss_rdat1(iss_rdat1), .iss_rdat2(iss_rdat2),
        .iss_imm(iss_imm)
    );

    // writeback port drives the write side
    issue_regfile u_regfile (
        .CLK(CLK), .nRST(nRST), .wen(wb_en), .wsel(wb_sel), .wdata(wb_data),
        .rsel1(rsel1), .rsel2(rsel2), .rdat1(rdat1), .rdat2(rdat2)
    );

endmodule

// File: tests/issue_stage_tb.sv
// issue stage testbench
`timescale 1ns/100ps

module issue_stage_tb;
    import issue_pkg::*;

    // one expected issue as seen on the issue port
    typedef struct packed {
        row_mask_t fu_en;
        op_type_t  op;
        regbits_t  rd;
        word_t     rdat1;
        word_t     rdat2;
        word_t     imm;
    } issue_rec_t;

    localparam int WAIT_LIMIT = 60;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic      CLK;
    logic      nRST;
    logic      disp_en;
    fu_row_e   disp_fu;
    regbits_t  disp_rs1;
    regbits_t  disp_rs2;
    regbits_t  disp_rd;
    word_t     disp_imm;
    op_type_t  disp_op;
    logic      disp_i_type;
    logic      disp_lui;
    row_mask_t disp_wait;
    logic      wb_en;
    regbits_t  wb_sel;
    word_t     wb_data;
    row_mask_t fu_done;
    logic      branch_miss;
    row_mask_t fu_busy;
    logic      iss_valid;
    row_mask_t iss_fu_en;
    op_type_t  iss_op;
    regbits_t  iss_rd;
    word_t     iss_rdat1;
    word_t     iss_rdat2;
    word_t     iss_imm;

    // register model and the issues still to come in oldest first order
    word_t       model_regs [32];
    issue_rec_t  exp_q [$];
    string       test_name = "reset";
    logic [31:0] lfsr = 32'he7a4;

    issue_stage dut0 (
        .CLK(CLK), .nRST(nRST), .disp_en(disp_en), .disp_fu(disp_fu),
        .disp_rs1(disp_rs1), .disp_rs2(disp_rs2), .disp_rd(disp_rd),
        .disp_imm(disp_imm), .disp_op(disp_op), .disp_i_type(disp_i_type),
        .disp_lui(disp_lui), .disp_wait(disp_wait), .wb_en(wb_en), .wb_sel(wb_sel),
        .wb_data(wb_data), .fu_done(fu_done), .branch_miss(branch_miss),
        .fu_busy(fu_busy), .iss_valid(iss_valid), .iss_fu_en(iss_fu_en),
        .iss_op(iss_op), .iss_rd(iss_rd), .iss_rdat1(iss_rdat1),
        .iss_rdat2(iss_rdat2), .iss_imm(iss_imm)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic report_failure();
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string field, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Mismatch %s %s expected %h actual %h", test_name, field, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_reg(input string field, input regbits_t expected,
            input regbits_t actual);
        if (expected !== actual) begin
            $display("Mismatch %s %s expected %h actual %h", test_name, field, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_mask(input string field, input row_mask_t expected,
            input row_mask_t actual);
        if (expected !== actual) begin
            $display("Mismatch %s %s expected %b actual %b", test_name, field, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_op(input string field, input op_type_t expected,
            input op_type_t actual);
        if (expected !== actual) begin
            $display("Mismatch %s %s expected %h actual %h", test_name, field, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_bit(input string field, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("Mismatch %s %s expected %b actual %b", test_name, field, expected, actual);
            report_failure();
        end
    endtask

    // galois lfsr stepped once per bit
    function automatic logic rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = (lfsr >> 1) ^ (b ? LFSR_TAPS : 32'h0);
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    function automatic row_mask_t fu_mask(input fu_row_e fu);
        case (fu)
            FU_ALU:  return 3'b001;
            FU_LDST: return 3'b010;
            default: return 3'b100;
        endcase
    endfunction

    // expected issue port contents for a dispatched instruction
    function automatic issue_rec_t predict_issue(input fu_row_e fu, input regbits_t rs1,
            input regbits_t rs2, input regbits_t rd, input word_t imm, input op_type_t op,
            input logic i_type, input logic lui);
        issue_rec_t rec;
        rec.fu_en = fu_mask(fu);
        rec.op    = op;
        rec.rd    = rd;
        rec.imm   = imm;
        // lui has no first source
        rec.rdat1 = lui ? 32'h0 : model_regs[rs1];
        // only the alu takes the immediate
        rec.rdat2 = (i_type && (fu == FU_ALU)) ? imm : model_regs[rs2];
        return rec;
    endfunction

    // every issue must match the oldest expected one
    initial begin
        issue_rec_t exp;
        forever begin
            @(negedge CLK);
            if (nRST && iss_valid) begin
                if (exp_q.size() == 0) begin
                    $display("%s raised an issue that no dispatch expected", test_name);
                    report_failure();
                end
                exp = exp_q.pop_front();
                check_mask("iss_fu_en", exp.fu_en, iss_fu_en);
                check_op("iss_op", exp.op, iss_op);
                check_reg("iss_rd", exp.rd, iss_rd);
                check_word("iss_rdat1", exp.rdat1, iss_rdat1);
                check_word("iss_rdat2", exp.rdat2, iss_rdat2);
                check_word("iss_imm", exp.imm, iss_imm);
            end
        end
    end

    task automatic dispatch_op(input fu_row_e fu, input regbits_t rs1, input regbits_t rs2,
            input regbits_t rd, input word_t imm, input op_type_t op, input logic i_type,
            input logic lui, input row_mask_t wait_mask);
        @(posedge CLK);
        disp_en     <= 1'b1;
        disp_fu     <= fu;
        disp_rs1    <= rs1;
        disp_rs2    <= rs2;
        disp_rd     <= rd;
        disp_imm    <= imm;
        disp_op     <= op;
        disp_i_type <= i_type;
        disp_lui    <= lui;
        disp_wait   <= wait_mask;
        @(posedge CLK);
        disp_en <= 1'b0;
    endtask

    // random payload; a flushed op is not expected to issue
    task automatic random_op(input fu_row_e fu, input row_mask_t wait_mask,
            input logic expected);
        regbits_t rs1;
        regbits_t rs2;
        regbits_t rd;
        word_t    imm;
        op_type_t op;
        logic     i_type;
        logic     lui;
        rs1    = regbits_t'(rand_bits(5));
        rs2    = regbits_t'(rand_bits(5));
        rd     = regbits_t'(rand_bits(5));
        imm    = rand_bits(32);
        op     = op_type_t'(rand_bits(4));
        i_type = rand_bit();
        lui    = rand_bit();
        if (expected) begin
            exp_q.push_back(predict_issue(fu, rs1, rs2, rd, imm, op, i_type, lui));
        end
        dispatch_op(fu, rs1, rs2, rd, imm, op, i_type, lui, wait_mask);
    endtask

    // register model follows the writeback port and keeps r0 at zero
    task automatic write_reg(input regbits_t sel, input word_t data);
        @(posedge CLK);
        wb_en   <= 1'b1;
        wb_sel  <= sel;
        wb_data <= data;
        if (sel != 5'd0) begin
            model_regs[sel] = data;
        end
    endtask

    task automatic stop_writes();
        @(posedge CLK);
        wb_en <= 1'b0;
    endtask

    task automatic complete_rows(input row_mask_t rows);
        @(posedge CLK);
        fu_done <= rows;
        @(posedge CLK);
        fu_done <= '0;
    endtask

    task automatic wait_drained();
        int cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge CLK);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout in %s, %0d issues never came", test_name, exp_q.size());
                report_failure();
            end
        end
    endtask

    task automatic wait_rows_free(input row_mask_t rows);
        int cycles = 0;
        @(negedge CLK);
        while ((fu_busy & rows) != '0) begin
            @(negedge CLK);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout in %s, rows %b stayed busy", test_name, fu_busy & rows);
                report_failure();
            end
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge CLK);
            check_bit("iss_valid", 1'b0, iss_valid);
        end
    endtask

    // same cycle writeback on the register that is read at select time
    task automatic bypass_read(input regbits_t r, input word_t data);
        dispatch_op(FU_ALU, r, r, 5'd3, 32'h55, 4'h2, 1'b0, 1'b0, '0);
        write_reg(r, data);
        exp_q.push_back(predict_issue(FU_ALU, r, r, 5'd3, 32'h55, 4'h2, 1'b0, 1'b0));
        stop_writes();
        wait_drained();
        complete_rows(3'b001);
        wait_rows_free(3'b001);
    endtask

    task automatic oldest_first(input fu_row_e first, input fu_row_e second);
        random_op(FU_BRANCH, '0, 1'b1);
        wait_drained();
        random_op(first, 3'b100, 1'b1);
        random_op(second, 3'b100, 1'b1);
        complete_rows(3'b100);
        wait_drained();
        complete_rows(3'b011);
        wait_rows_free(3'b111);
    endtask

    initial begin
        logic [31:0] sel;
        fu_row_e     fu;
        nRST        = 1'b0;
        disp_en     = 1'b0;
        disp_fu     = FU_ALU;
        disp_rs1    = '0;
        disp_rs2    = '0;
        disp_rd     = '0;
        disp_imm    = '0;
        disp_op     = '0;
        disp_i_type = 1'b0;
        disp_lui    = 1'b0;
        disp_wait   = '0;
        wb_en       = 1'b0;
        wb_sel      = '0;
        wb_data     = '0;
        fu_done     = '0;
        branch_miss = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;

        @(negedge CLK);
        check_bit("iss_valid", 1'b0, iss_valid);
        check_mask("fu_busy", '0, fu_busy);
        test_name = "reset and release";
        random_op(FU_ALU, '0, 1'b1);
        wait_drained();
        @(negedge CLK);
        check_mask("fu_busy", 3'b001, fu_busy);
        complete_rows(3'b001);
        wait_rows_free(3'b001);
        check_mask("fu_busy", '0, fu_busy);

        test_name = "operand forming";
        repeat (40) write_reg(regbits_t'(rand_bits(5)), rand_bits(32));
        stop_writes();
        repeat (30) begin
            sel = rand_bits(2) % 3;
            fu  = fu_row_e'(sel[1:0]);
            random_op(fu, '0, 1'b1);
            wait_drained();
            complete_rows(fu_mask(fu));
            wait_rows_free(fu_mask(fu));
        end

        test_name = "dependency wait";
        random_op(FU_BRANCH, '0, 1'b1);
        wait_drained();
        random_op(FU_ALU, 3'b100, 1'b1);
        expect_quiet(8);
        complete_rows(3'b100);
        wait_drained();
        complete_rows(3'b001);
        wait_rows_free(3'b101);

        test_name = "oldest first";
        oldest_first(FU_ALU, FU_LDST);
        oldest_first(FU_LDST, FU_ALU);

        test_name = "flush";
        random_op(FU_BRANCH, '0, 1'b1);
        wait_drained();
        random_op(FU_ALU, 3'b100, 1'b0);
        random_op(FU_LDST, 3'b100, 1'b0);
        // release both waiting rows so the flush lands on their ready cycle
        complete_rows(3'b100);
        @(posedge CLK);
        branch_miss <= 1'b1;
        @(posedge CLK);
        branch_miss <= 1'b0;
        @(negedge CLK);
        check_mask("fu_busy", '0, fu_busy);
        expect_quiet(8);
        random_op(FU_LDST, '0, 1'b1);
        wait_drained();
        complete_rows(3'b010);
        wait_rows_free(3'b010);

        test_name = "bypass and r0";
        bypass_read(5'd7, 32'hcafe_0107);
        bypass_read(5'd0, 32'hdead_beef);
        exp_q.push_back(predict_issue(FU_ALU, 5'd0, 5'd0, 5'd9, 32'h1, 4'h5, 1'b0, 1'b0));
        dispatch_op(FU_ALU, 5'd0, 5'd0, 5'd9, 32'h1, 4'h5, 1'b0, 1'b0, '0);
        wait_drained();
        complete_rows(3'b001);
        wait_rows_free(3'b001);

        $display("Verification passed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+rtl
rtl/issue_pkg.sv
rtl/issue_regfile.sv
rtl/dispatch_intake.sv
rtl/fu_status_table.sv
rtl/operand_read.sv
rtl/issue_stage.sv
tests/issue_stage_tb.sv
